//--- uart_periph.f
+incdir+include
logic/uart_reg_pkg.sv
logic/uart_line_pkg.sv
logic/uart_regs.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_periph.sv
test/tb_uart_periph.sv

//--- run_sim.sh
#!/bin/sh
# Build the UART testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f uart_periph.f --top-module tb_uart_periph \
  --Mdir obj_dir -o sim_uart_periph > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_uart_periph > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"

//--- test/tb_uart_periph.sv
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module tb_uart_periph;

  // Bit period is BAUD+1 mclk cycles
  localparam int BAUD    = 15;
  localparam int BIT_CYC = BAUD + 1;
  // Six frames plus slack, doubled
  localparam int TIMEOUT_CYC = 2 * (6 * 10 * BIT_CYC + 200);

  // Status byte bit positions
  localparam int ST_TX_EMPTY = 7;
  localparam int ST_TX_PND   = 6;
  localparam int ST_RX_OVF   = 5;
  localparam int ST_RX_PND   = 4;
  localparam int ST_TX_FULL  = 3;
  localparam int ST_TX_BUSY  = 2;

  localparam uart_reg_pkg::per_addr_t BASE_WADDR = `UART_BASE_WADDR;

  logic                    mclk;
  logic                    puc_rst;
  logic                    per_en;
  uart_reg_pkg::per_addr_t per_addr;
  uart_reg_pkg::per_we_t   per_we;
  uart_reg_pkg::per_data_t per_din;
  uart_reg_pkg::per_data_t per_dout;
  logic                    uart_rxd;
  logic                    uart_txd;
  logic                    irq_uart_rx;
  logic                    irq_uart_tx;

  integer seed;
  int     cycle_cnt = 0;

  uart_periph u_uart_periph (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_en      (per_en),
    .per_addr    (per_addr),
    .per_we      (per_we),
    .per_din     (per_din),
    .uart_rxd    (uart_rxd),
    .per_dout    (per_dout),
    .uart_txd    (uart_txd),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  // 8 ns clock
  always #4 mclk = ~mclk;

  // Run limit in cycles
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  //==========================================================================
  // Helpers
  //==========================================================================

  task automatic check_eq(input string name, input logic [15:0] actual,
                          input logic [15:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s is 0x%h, expected 0x%h",
               $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  // Word address of a byte offset
  function automatic uart_reg_pkg::per_addr_t reg_waddr(input logic [2:0] ofs);
    return {BASE_WADDR[13:2], ofs[2:1]};
  endfunction

  // One bus cycle, inputs change on the falling edge
  task automatic bus_write(input uart_reg_pkg::per_addr_t addr, input uart_reg_pkg::per_we_t we,
                           input uart_reg_pkg::per_data_t din);
    @(negedge mclk);
    per_en   = 1'b1;
    per_addr = addr;
    per_we   = we;
    per_din  = din;
    @(negedge mclk);
    per_en   = 1'b0;
    per_we   = '0;
    per_din  = '0;
  endtask

  // Read data sampled on the falling edge that ends the access
  task automatic bus_read(input uart_reg_pkg::per_addr_t addr,
                          output uart_reg_pkg::per_data_t dout);
    @(negedge mclk);
    per_en   = 1'b1;
    per_addr = addr;
    per_we   = '0;
    @(negedge mclk);
    dout     = per_dout;
    per_en   = 1'b0;
  endtask

  // Odd offsets in the high lane
  task automatic reg_write(input logic [2:0] ofs, input uart_reg_pkg::uart_byte_t val);
    bus_write(reg_waddr(ofs), ofs[0] ? 2'b10 : 2'b01, ofs[0] ? {val, 8'h00} : {8'h00, val});
  endtask

  task automatic reg_read(input logic [2:0] ofs, output uart_reg_pkg::uart_byte_t val);
    uart_reg_pkg::per_data_t d;
    bus_read(reg_waddr(ofs), d);
    val = ofs[0] ? d[15:8] : d[7:0];
  endtask

  // Poll one status bit, cycle limit catches a stuck flag
  task automatic wait_status(input int bit_pos, input logic value);
    uart_reg_pkg::uart_byte_t st;
    reg_read(`UART_OFS_STATUS, st);
    while (st[bit_pos] !== value) begin
      reg_read(`UART_OFS_STATUS, st);
    end
  endtask

  task automatic next_byte(output uart_reg_pkg::uart_byte_t val);
    logic [31:0] r;
    r   = $random(seed);
    val = r[7:0];
  endtask

  // 8N1 on the receive line, LSB first
  task automatic send_frame(input uart_reg_pkg::uart_byte_t data);
    @(negedge mclk);
    uart_rxd = 1'b0;
    repeat (BIT_CYC) @(negedge mclk);
    for (int i = 0; i < 8; i++) begin
      uart_rxd = data[i];
      repeat (BIT_CYC) @(negedge mclk);
    end
    uart_rxd = 1'b1;
    repeat (BIT_CYC) @(negedge mclk);
  endtask

  // Start bit lands in bit 0, stop bit in bit 9
  task automatic capture_frame(output logic [9:0] frame);
    @(negedge uart_txd);
    repeat (BIT_CYC / 2) @(negedge mclk);
    frame[0] = uart_txd;
    for (int i = 1; i < 10; i++) begin
      repeat (BIT_CYC) @(negedge mclk);
      frame[i] = uart_txd;
    end
  endtask

  //==========================================================================
  // Directed tests
  //==========================================================================

  task automatic test_reset_regs();
    uart_reg_pkg::per_data_t d;
    for (int w = 0; w < 4; w++) begin
      bus_read(reg_waddr(3'(2 * w)), d);
      check_eq("reset word", d, 16'h0000);
    end
    // Outside the block
    bus_read(14'h0044, d);
    check_eq("unselected read", d, 16'h0000);
    check_eq("uart_txd idle", 16'(uart_txd), 16'h0001);
    check_eq("irq_uart_rx", 16'(irq_uart_rx), 16'h0000);
    check_eq("irq_uart_tx", 16'(irq_uart_tx), 16'h0000);
    reg_write(`UART_OFS_CTRL, 8'hFF);
    bus_read(reg_waddr(`UART_OFS_CTRL), d);
    check_eq("ctrl mask", d, 16'h0071);
    // Each baud byte in its own lane
    reg_write(`UART_OFS_BAUD_LO, 8'hA5);
    bus_read(reg_waddr(`UART_OFS_BAUD_LO), d);
    check_eq("baud_lo lane", d, 16'h00A5);
    reg_write(`UART_OFS_BAUD_LO, 8'h00);
    reg_write(`UART_OFS_BAUD_HI, 8'h3C);
    bus_read(reg_waddr(`UART_OFS_BAUD_HI), d);
    check_eq("baud_hi lane", d, 16'h3C00);
    // Working setup for the serial tests
    reg_write(`UART_OFS_BAUD_HI, 8'(BAUD >> 8));
    reg_write(`UART_OFS_BAUD_LO, 8'(BAUD));
    reg_write(`UART_OFS_CTRL, 8'h01);
  endtask

  task automatic test_tx_frame();
    uart_reg_pkg::uart_byte_t data;
    uart_reg_pkg::uart_byte_t st;
    logic [9:0]               frame;
    next_byte(data);
    reg_write(`UART_OFS_DATA_TX, data);
    capture_frame(frame);
    check_eq("tx frame", 16'(frame), 16'({1'b1, data, 1'b0}));
    wait_status(ST_TX_BUSY, 1'b0);
    reg_read(`UART_OFS_STATUS, st);
    check_eq("status after tx", 16'(st), 16'h00C0);
    // Interrupt only with ien_tx
    check_eq("irq_uart_tx masked", 16'(irq_uart_tx), 16'h0000);
    reg_write(`UART_OFS_CTRL, 8'h41);
    check_eq("irq_uart_tx enabled", 16'(irq_uart_tx), 16'h0001);
    reg_write(`UART_OFS_STATUS, 8'hC0);
    check_eq("irq_uart_tx cleared", 16'(irq_uart_tx), 16'h0000);
    reg_write(`UART_OFS_CTRL, 8'h01);
  endtask

  task automatic test_tx_back_to_back();
    uart_reg_pkg::uart_byte_t data_a;
    uart_reg_pkg::uart_byte_t data_b;
    uart_reg_pkg::uart_byte_t st;
    logic [9:0]               frame_a;
    logic [9:0]               frame_b;
    next_byte(data_a);
    next_byte(data_b);
    reg_write(`UART_OFS_DATA_TX, data_a);
    fork
      capture_frame(frame_a);
      begin
        // Second byte waits in the slot
        reg_write(`UART_OFS_DATA_TX, data_b);
        reg_read(`UART_OFS_STATUS, st);
        check_eq("tx_full", 16'(st[ST_TX_FULL]), 16'h0001);
      end
    join
    check_eq("first frame", 16'(frame_a), 16'({1'b1, data_a, 1'b0}));
    capture_frame(frame_b);
    check_eq("second frame", 16'(frame_b), 16'({1'b1, data_b, 1'b0}));
    reg_read(`UART_OFS_STATUS, st);
    check_eq("tx_pnd after first", 16'(st[ST_TX_PND]), 16'h0001);
    check_eq("tx_empty too early", 16'(st[ST_TX_EMPTY]), 16'h0000);
    wait_status(ST_TX_BUSY, 1'b0);
    reg_read(`UART_OFS_STATUS, st);
    check_eq("status after both", 16'(st), 16'h00C0);
    reg_write(`UART_OFS_STATUS, 8'hC0);
  endtask

  task automatic test_rx_frame();
    uart_reg_pkg::uart_byte_t data;
    uart_reg_pkg::uart_byte_t got;
    uart_reg_pkg::uart_byte_t st;
    next_byte(data);
    send_frame(data);
    wait_status(ST_RX_PND, 1'b1);
    reg_read(`UART_OFS_DATA_RX, got);
    check_eq("data_rx", 16'(got), 16'(data));
    reg_read(`UART_OFS_STATUS, st);
    check_eq("status after rx", 16'(st), 16'h0010);
    check_eq("irq_uart_rx masked", 16'(irq_uart_rx), 16'h0000);
    reg_write(`UART_OFS_CTRL, 8'h11);
    check_eq("irq_uart_rx enabled", 16'(irq_uart_rx), 16'h0001);
    // Write one to clear
    reg_write(`UART_OFS_STATUS, 8'h10);
    check_eq("irq_uart_rx cleared", 16'(irq_uart_rx), 16'h0000);
    reg_read(`UART_OFS_STATUS, st);
    check_eq("rx_pnd cleared", 16'(st), 16'h0000);
  endtask

  task automatic test_rx_overflow();
    uart_reg_pkg::uart_byte_t data_a;
    uart_reg_pkg::uart_byte_t data_b;
    uart_reg_pkg::uart_byte_t got;
    uart_reg_pkg::uart_byte_t st;
    next_byte(data_a);
    next_byte(data_b);
    // Only the overflow interrupt enabled
    reg_write(`UART_OFS_CTRL, 8'h21);
    send_frame(data_a);
    send_frame(data_b);
    wait_status(ST_RX_OVF, 1'b1);
    reg_read(`UART_OFS_DATA_RX, got);
    check_eq("data_rx second", 16'(got), 16'(data_b));
    reg_read(`UART_OFS_STATUS, st);
    check_eq("status overflow", 16'(st), 16'h0030);
    check_eq("irq_uart_rx ovflw", 16'(irq_uart_rx), 16'h0001);
    reg_write(`UART_OFS_STATUS, 8'h20);
    check_eq("irq_uart_rx ovflw clr", 16'(irq_uart_rx), 16'h0000);
    reg_write(`UART_OFS_STATUS, 8'h10);
    reg_write(`UART_OFS_CTRL, 8'h01);
  endtask

  task automatic test_disable();
    uart_reg_pkg::uart_byte_t st;
    // All-zero byte keeps the line low mid-frame
    reg_write(`UART_OFS_DATA_TX, 8'h00);
    @(negedge uart_txd);
    repeat (3 * BIT_CYC) @(negedge mclk);
    check_eq("uart_txd mid-frame", 16'(uart_txd), 16'h0000);
    reg_write(`UART_OFS_CTRL, 8'h00);
    @(negedge mclk);
    check_eq("uart_txd after disable", 16'(uart_txd), 16'h0001);
    reg_read(`UART_OFS_STATUS, st);
    check_eq("status after disable", 16'(st), 16'h0000);
    repeat (BIT_CYC) @(negedge mclk);
    check_eq("uart_txd stays idle", 16'(uart_txd), 16'h0001);
  endtask

  //==========================================================================
  // Sequence
  //==========================================================================

  initial begin
    mclk     = 1'b0;
    puc_rst  = 1'b1;
    per_en   = 1'b0;
    per_addr = '0;
    per_we   = '0;
    per_din  = '0;
    uart_rxd = 1'b1;
    seed     = 32'h91a6_272b;
    repeat (16) @(negedge mclk);
    puc_rst = 1'b0;
    test_reset_regs();
    test_tx_frame();
    test_tx_back_to_back();
    test_rx_frame();
    test_rx_overflow();
    test_disable();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/uart_periph.sv
`default_nettype none
`timescale 1ns/1ps

module uart_periph (
  input  wire                          mclk,
  input  wire                          puc_rst,
  input  wire                          per_en,
  input  wire uart_reg_pkg::per_addr_t per_addr,
  input  wire uart_reg_pkg::per_we_t   per_we,
  input  wire uart_reg_pkg::per_data_t per_din,
  input  wire                          uart_rxd,
  output uart_reg_pkg::per_data_t      per_dout,
  output logic                         uart_txd,
  output logic                         irq_uart_rx,
  output logic                         irq_uart_tx
);

  uart_reg_pkg::uart_cfg_t   cfg;
  logic                      tx_load;
  uart_reg_pkg::uart_byte_t  tx_data;
  uart_line_pkg::tx_event_t  tx_evt;
  uart_line_pkg::rx_event_t  rx_evt;

  // Bus side
  uart_regs u_uart_regs (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_en      (per_en),
    .per_addr    (per_addr),
    .per_we      (per_we),
    .per_din     (per_din),
    .tx_evt      (tx_evt),
    .rx_evt      (rx_evt),
    .per_dout    (per_dout),
    .cfg         (cfg),
    .tx_load     (tx_load),
    .tx_data     (tx_data),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  // Serial input
  uart_rx u_uart_rx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .cfg      (cfg),
    .uart_rxd (uart_rxd),
    .rx_evt   (rx_evt)
  );

  // Serial output
  uart_tx u_uart_tx (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .cfg      (cfg),
    .tx_load  (tx_load),
    .tx_data  (tx_data),
    .uart_txd (uart_txd),
    .tx_evt   (tx_evt)
  );

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_tx (
  input  wire                           mclk,
  input  wire                           puc_rst,
  input  wire uart_reg_pkg::uart_cfg_t  cfg,
  input  wire                           tx_load,
  input  wire uart_reg_pkg::uart_byte_t tx_data,
  output logic                          uart_txd,
  output uart_line_pkg::tx_event_t      tx_evt
);

  uart_line_pkg::frame_bit_t tx_bit;
  uart_reg_pkg::baud_div_t   tx_cnt;
  logic                      tx_pending;
  logic                      tx_start;
  logic                      tx_bit_inc;
  logic                      tx_last;
  logic                      tx_last_dly;
  logic [8:0]                tx_buf;

  //==========================================================================
  // Pending slot
  //==========================================================================

  assign tx_start = (tx_bit == '0) & tx_pending & cfg.en;

  // A new load replaces a waiting character
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      tx_pending <= 1'b0;
    else if (tx_load)
      tx_pending <= 1'b1;
    else if (!cfg.en || tx_start)
      tx_pending <= 1'b0;
  end

  //==========================================================================
  // Bit counter and shifter
  //==========================================================================

  assign tx_bit_inc = (tx_bit != '0) & (tx_cnt == '0);
  assign tx_last    = (tx_bit == `UART_TX_LAST_BIT);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_bit <= '0;
      tx_cnt <= '0;
      tx_buf <= {9{`UART_LINE_IDLE}};
    end else if (!cfg.en) begin
      tx_bit <= '0;
      tx_cnt <= '0;
      tx_buf <= {9{`UART_LINE_IDLE}};
    end else if (tx_start) begin
      // Start bit goes out on this edge
      tx_bit <= 4'd1;
      tx_cnt <= cfg.baud;
      tx_buf <= {tx_data, 1'b0};
    end else if (tx_last) begin
      tx_bit <= '0;
    end else if (tx_bit_inc) begin
      // Ones from the top form the stop bit
      tx_bit <= tx_bit + 4'd1;
      tx_cnt <= cfg.baud;
      tx_buf <= {1'b1, tx_buf[8:1]};
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - 16'd1;
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      tx_last_dly <= 1'b0;
    else
      tx_last_dly <= tx_last;
  end

  assign uart_txd       = tx_buf[0];
  assign tx_evt.done    = tx_last & ~tx_last_dly;
  assign tx_evt.busy    = (tx_bit != '0) | tx_pending;
  assign tx_evt.pending = tx_pending;

  // Line back to idle one edge after disable
  a_txd_idle : assert property (@(posedge mclk) disable iff (puc_rst)
    !cfg.en |=> uart_txd);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_rx (
  input  wire                          mclk,
  input  wire                          puc_rst,
  input  wire uart_reg_pkg::uart_cfg_t cfg,
  input  wire                          uart_rxd,
  output uart_line_pkg::rx_event_t     rx_evt
);

  //==========================================================================
  // Line synchronizer and majority filter
  //==========================================================================

  logic [1:0] rxd_sync;
  logic [1:0] rxd_buf;
  logic       rxd_maj;
  logic       rxd_maj_nxt;
  logic       rxd_fe;

  // Two flops against metastability, line idles high
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rxd_sync <= {2{`UART_LINE_IDLE}};
      rxd_buf  <= {2{`UART_LINE_IDLE}};
      rxd_maj  <= `UART_LINE_IDLE;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
      rxd_buf  <= {rxd_buf[0], rxd_sync[1]};
      rxd_maj  <= rxd_maj_nxt;
    end
  end

  // Two of three samples decide
  assign rxd_maj_nxt = (rxd_sync[1] & rxd_buf[0]) |
                       (rxd_sync[1] & rxd_buf[1]) |
                       (rxd_buf[0]  & rxd_buf[1]);

  // Filtered falling edge
  assign rxd_fe = rxd_maj & ~rxd_maj_nxt;

  //==========================================================================
  // Bit counter and sampling
  //==========================================================================

  uart_line_pkg::frame_bit_t rx_bit;
  uart_reg_pkg::baud_div_t   rx_cnt;
  logic                      rx_start;
  logic                      rx_bit_inc;
  logic                      rx_last;
  logic                      rx_last_dly;
  uart_reg_pkg::uart_byte_t  rx_buf;

  assign rx_start   = (rx_bit == '0) & rxd_fe;
  assign rx_bit_inc = (rx_bit != '0) & (rx_cnt == '0);
  assign rx_last    = (rx_bit == `UART_RX_LAST_BIT);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_bit <= '0;
      rx_cnt <= '0;
    end else if (!cfg.en) begin
      rx_bit <= '0;
      rx_cnt <= '0;
    end else if (rx_start) begin
      // Half a period lands the samples mid-bit
      rx_bit <= 4'd1;
      rx_cnt <= {1'b0, cfg.baud[15:1]};
    end else if (rx_last) begin
      rx_bit <= '0;
    end else if (rx_bit_inc) begin
      rx_bit <= rx_bit + 4'd1;
      rx_cnt <= cfg.baud;
    end else if (rx_cnt != '0) begin
      rx_cnt <= rx_cnt - 16'd1;
    end
  end

  // LSB first, start bit falls out of the bottom
  always_ff @(posedge mclk) begin
    if (rx_bit_inc)
      rx_buf <= {rxd_maj, rx_buf[7:1]};
  end

  // One pulse per frame
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      rx_last_dly <= 1'b0;
    else
      rx_last_dly <= rx_last;
  end

  assign rx_evt.done = rx_last & ~rx_last_dly;
  assign rx_evt.data = rx_buf;
  assign rx_evt.busy = (rx_bit != '0);

  a_rx_bit_range : assert property (@(posedge mclk) disable iff (puc_rst)
    rx_bit <= `UART_RX_LAST_BIT);

endmodule

`default_nettype wire

//--- logic/uart_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_regs (
  input  wire                           mclk,
  input  wire                           puc_rst,
  input  wire                           per_en,
  input  wire uart_reg_pkg::per_addr_t  per_addr,
  input  wire uart_reg_pkg::per_we_t    per_we,
  input  wire uart_reg_pkg::per_data_t  per_din,
  input  wire uart_line_pkg::tx_event_t tx_evt,
  input  wire uart_line_pkg::rx_event_t rx_evt,
  output uart_reg_pkg::per_data_t       per_dout,
  output uart_reg_pkg::uart_cfg_t       cfg,
  output logic                          tx_load,
  output uart_reg_pkg::uart_byte_t      tx_data,
  output logic                          irq_uart_rx,
  output logic                          irq_uart_tx
);

  localparam uart_reg_pkg::per_addr_t BASE_WADDR = `UART_BASE_WADDR;

  // Write hit on one register, lane picked by offset parity
  function automatic logic wr_hit(input logic [2:0] ofs, input logic [1:0] word,
                                  input uart_reg_pkg::per_we_t we);
    return (word == ofs[2:1]) && we[ofs[0]];
  endfunction

  // Byte taken from the lane of a register
  function automatic uart_reg_pkg::uart_byte_t lane_din(input logic [2:0] ofs,
                                                        input uart_reg_pkg::per_data_t din);
    return ofs[0] ? din[15:8] : din[7:0];
  endfunction

  // Register placed in its lane, zero elsewhere
  function automatic uart_reg_pkg::per_data_t lane_dout(input logic [2:0] ofs,
                                                        input logic [1:0] word,
                                                        input uart_reg_pkg::uart_byte_t val);
    uart_reg_pkg::per_data_t d;
    d = '0;
    if (word == ofs[2:1]) begin
      if (ofs[0]) begin
        d[15:8] = val;
      end else begin
        d[7:0] = val;
      end
    end
    return d;
  endfunction

  //==========================================================================
  // Address decode
  //==========================================================================

  logic       reg_sel;
  logic [1:0] reg_word;
  logic       reg_rd;
  logic       ctrl_wr;
  logic       status_wr;
  logic       baud_lo_wr;
  logic       baud_hi_wr;

  // Block hit on the upper word address bits
  assign reg_sel    = per_en & (per_addr[13:2] == BASE_WADDR[13:2]);
  assign reg_word   = per_addr[1:0];
  assign reg_rd     = reg_sel & ~|per_we;

  assign ctrl_wr    = reg_sel & wr_hit(`UART_OFS_CTRL,    reg_word, per_we);
  assign status_wr  = reg_sel & wr_hit(`UART_OFS_STATUS,  reg_word, per_we);
  assign baud_lo_wr = reg_sel & wr_hit(`UART_OFS_BAUD_LO, reg_word, per_we);
  assign baud_hi_wr = reg_sel & wr_hit(`UART_OFS_BAUD_HI, reg_word, per_we);
  assign tx_load    = reg_sel & wr_hit(`UART_OFS_DATA_TX, reg_word, per_we);

  //==========================================================================
  // Register file
  //==========================================================================

  uart_reg_pkg::uart_byte_t ctrl;
  uart_reg_pkg::uart_byte_t baud_lo;
  uart_reg_pkg::uart_byte_t baud_hi;
  uart_reg_pkg::uart_byte_t data_rx;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ctrl    <= `UART_REG_RST;
      baud_lo <= `UART_REG_RST;
      baud_hi <= `UART_REG_RST;
      tx_data <= `UART_REG_RST;
      data_rx <= `UART_REG_RST;
    end else begin
      // Control keeps only the enable and interrupt enables
      if (ctrl_wr)
        ctrl <= lane_din(`UART_OFS_CTRL, per_din) & `UART_CTRL_MASK;
      if (baud_lo_wr)
        baud_lo <= lane_din(`UART_OFS_BAUD_LO, per_din);
      if (baud_hi_wr)
        baud_hi <= lane_din(`UART_OFS_BAUD_HI, per_din);
      if (tx_load)
        tx_data <= lane_din(`UART_OFS_DATA_TX, per_din);
      // Received byte lands with its pending flag
      if (rx_evt.done)
        data_rx <= rx_evt.data;
    end
  end

  assign cfg.en   = ctrl[0];
  assign cfg.baud = {baud_hi, baud_lo};

  //==========================================================================
  // Pending flags and status
  //==========================================================================

  // Bits 3..0 are tx_empty, tx, rx_ovflw, rx
  logic [3:0]               pnd;
  logic [3:0]               pnd_set;
  logic [3:0]               pnd_clr;
  uart_reg_pkg::uart_byte_t status_din;
  uart_reg_pkg::uart_byte_t status;

  assign pnd_set = {tx_evt.done & ~tx_evt.pending,
                    tx_evt.done,
                    rx_evt.done & pnd[0],
                    rx_evt.done};

  // Write one to clear, upper nibble of the status byte
  assign status_din = lane_din(`UART_OFS_STATUS, per_din);
  assign pnd_clr    = {4{status_wr}} & status_din[7:4];

  // Set wins over a clear in the same cycle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      pnd <= '0;
    end else begin
      pnd <= (pnd & ~pnd_clr) | pnd_set;
    end
  end

  assign status = {pnd,
                   tx_evt.busy & tx_evt.pending,
                   tx_evt.busy,
                   1'b0,
                   rx_evt.busy};

  //==========================================================================
  // Read mux and interrupts
  //==========================================================================

  assign per_dout = {16{reg_rd}} & (lane_dout(`UART_OFS_CTRL,    reg_word, ctrl)    |
                                    lane_dout(`UART_OFS_STATUS,  reg_word, status)  |
                                    lane_dout(`UART_OFS_BAUD_LO, reg_word, baud_lo) |
                                    lane_dout(`UART_OFS_BAUD_HI, reg_word, baud_hi) |
                                    lane_dout(`UART_OFS_DATA_TX, reg_word, tx_data) |
                                    lane_dout(`UART_OFS_DATA_RX, reg_word, data_rx));

  // Enables are ctrl bits 6, 5 and 4
  assign irq_uart_rx = (pnd[0] & ctrl[4]) | (pnd[1] & ctrl[5]);
  assign irq_uart_tx = pnd[2] & ctrl[6];

endmodule

`default_nettype wire

//--- logic/uart_line_pkg.sv
`default_nettype none

`include "uart_macros.svh"

package uart_line_pkg;

  // Position inside a serial frame, zero when idle
  typedef logic [`UART_FRAME_W-1:0] frame_bit_t;

  // Receiver report
  typedef struct packed {
    logic                     done;
    uart_reg_pkg::uart_byte_t data;
    logic                     busy;
  } rx_event_t;

  // Transmitter report
  typedef struct packed {
    logic done;
    // Frame running or character waiting
    logic busy;
    logic pending;
  } tx_event_t;

endpackage

`default_nettype wire

//--- logic/uart_reg_pkg.sv
`default_nettype none

`include "uart_macros.svh"

package uart_reg_pkg;

  //==========================================================================
  // Peripheral bus side
  //==========================================================================

  // Word address as seen by the peripheral
  typedef logic [`UART_ADDR_W-1:0] per_addr_t;

  // Bus data word and its byte write enables
  typedef logic [`UART_DATA_W-1:0] per_data_t;
  typedef logic [`UART_WE_W-1:0]   per_we_t;

  // One character or one register
  typedef logic [`UART_BYTE_W-1:0] uart_byte_t;

  // Bit period minus one, in mclk cycles
  typedef logic [`UART_BAUD_W-1:0] baud_div_t;

  // Settings shared by both serial blocks
  typedef struct packed {
    logic      en;
    baud_div_t baud;
  } uart_cfg_t;

endpackage

`default_nettype wire

//--- include/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Block placement on the peripheral bus (word address)
`define UART_BASE_WADDR   14'h0040

// Byte offsets, even in the low lane and odd in the high lane
`define UART_OFS_CTRL     3'd0
`define UART_OFS_STATUS   3'd1
`define UART_OFS_BAUD_LO  3'd2
`define UART_OFS_BAUD_HI  3'd3
`define UART_OFS_DATA_TX  3'd4
`define UART_OFS_DATA_RX  3'd5

// Writable control bits
`define UART_CTRL_MASK    8'h71

// Field widths
`define UART_ADDR_W       14
`define UART_DATA_W       16
`define UART_WE_W         2
`define UART_BYTE_W       8
`define UART_BAUD_W       16
`define UART_FRAME_W      4

// Frame end positions of the bit counters
`define UART_TX_LAST_BIT  4'd11
`define UART_RX_LAST_BIT  4'd10

// Reset values
`define UART_REG_RST      8'h00
`define UART_LINE_IDLE    1'b1

`endif
